// ==== source/alu_pkg.sv ====
`default_nettype none

package alu_pkg;

  localparam int XLEN     = 32;
  localparam int OP_W     = 19;
  localparam int SHAMT_W  = 5;

  typedef logic [XLEN-1:0]   word_t;
  typedef logic [2*XLEN-1:0] dword_t;
  typedef logic [OP_W-1:0]   alu_op_t;
  typedef logic [SHAMT_W-1:0] shamt_t;

  // one-hot bit positions of alu_op
  localparam int OP_ADD   = 0;
  localparam int OP_SUB   = 1;
  localparam int OP_SLT   = 2;
  localparam int OP_SLTU  = 3;
  localparam int OP_AND   = 4;
  localparam int OP_NOR   = 5;
  localparam int OP_OR    = 6;
  localparam int OP_XOR   = 7;
  localparam int OP_SLL   = 8;
  localparam int OP_SRL   = 9;
  localparam int OP_SRA   = 10;
  localparam int OP_LUI   = 11;
  localparam int OP_MUL   = 12;
  localparam int OP_MULH  = 13;
  localparam int OP_MULHU = 14;
  localparam int OP_DIV   = 15;
  localparam int OP_DIVU  = 16;
  localparam int OP_MOD   = 17;
  localparam int OP_MODU  = 18;

  localparam int DIV_STEPS      = 32;
  localparam int DIV_CNT_W      = $clog2(DIV_STEPS + 1);
  localparam int MUL_W          = XLEN + 1;   // sign or zero extended operand
  localparam int MUL_PP_ROWS    = MUL_W + 1;  // partial products plus correction row
  localparam int MUL_CSA_LAYERS = 8;          // 34 rows down to 2

  typedef enum logic [1:0] {IDLE, MUL_WAIT, DIV_WAIT} ctrl_state_t;

endpackage

`default_nettype wire

// ==== source/long_op_if.sv ====
`timescale 1ns/1ns
`default_nettype none

// start/done link between the control FSM and one multi-cycle unit
interface long_op_if import alu_pkg::*; ();

  logic  start;      // one-cycle pulse
  logic  is_signed;  // level, held with the op
  word_t src1;
  word_t src2;
  word_t res_lo;     // product low or quotient
  word_t res_hi;     // product high or remainder
  logic  done;       // one-cycle pulse

  modport ctrl (
    output start, is_signed, src1, src2,
    input  res_lo, res_hi, done
  );

  modport unit (
    input  start, is_signed, src1, src2,
    output res_lo, res_hi, done
  );

endinterface

`default_nettype wire

// ==== source/alu_simple.sv ====
`timescale 1ns/1ns
`default_nettype none

module alu_simple import alu_pkg::*; (
  input  alu_op_t alu_op,
  input  word_t   src1,
  input  word_t   src2,
  output word_t   result
);

  logic            use_sub;
  word_t           adder_b;
  logic [XLEN:0]   adder_sum;  // carry out in the top bit
  word_t           adder_res;
  logic            adder_cout;
  word_t           slt_res;
  word_t           sltu_res;
  word_t           and_res;
  word_t           or_res;
  word_t           nor_res;
  word_t           xor_res;
  word_t           sll_res;
  dword_t          sr64_res;
  word_t           sr_res;
  shamt_t          shamt;

  // one adder for add, sub and both compares
  assign use_sub   = alu_op[OP_SUB] | alu_op[OP_SLT] | alu_op[OP_SLTU];
  assign adder_b   = use_sub ? ~src2 : src2;
  assign adder_sum = {1'b0, src1} + {1'b0, adder_b} + {{XLEN{1'b0}}, use_sub};
  assign adder_res  = adder_sum[XLEN-1:0];
  assign adder_cout = adder_sum[XLEN];

  // src1 < src2, signed: differing signs decide, else the difference sign
  assign slt_res  = {{(XLEN-1){1'b0}},
                     (src1[XLEN-1] & ~src2[XLEN-1]) |
                     (~(src1[XLEN-1] ^ src2[XLEN-1]) & adder_res[XLEN-1])};
  assign sltu_res = {{(XLEN-1){1'b0}}, ~adder_cout};  // borrow out

  assign and_res = src1 & src2;
  assign or_res  = src1 | src2;
  assign nor_res = ~or_res;
  assign xor_res = src1 ^ src2;

  assign shamt   = src2[SHAMT_W-1:0];
  assign sll_res = src1 << shamt;

  // upper half filled with the sign only for sra
  assign sr64_res = {{XLEN{alu_op[OP_SRA] & src1[XLEN-1]}}, src1} >> shamt;
  assign sr_res   = sr64_res[XLEN-1:0];

  // long ops fall through as zero
  assign result = ({XLEN{alu_op[OP_ADD] | alu_op[OP_SUB]}} & adder_res)
                | ({XLEN{alu_op[OP_SLT]}}                  & slt_res)
                | ({XLEN{alu_op[OP_SLTU]}}                 & sltu_res)
                | ({XLEN{alu_op[OP_AND]}}                  & and_res)
                | ({XLEN{alu_op[OP_NOR]}}                  & nor_res)
                | ({XLEN{alu_op[OP_OR]}}                   & or_res)
                | ({XLEN{alu_op[OP_XOR]}}                  & xor_res)
                | ({XLEN{alu_op[OP_SLL]}}                  & sll_res)
                | ({XLEN{alu_op[OP_SRL] | alu_op[OP_SRA]}} & sr_res)
                | ({XLEN{alu_op[OP_LUI]}}                  & src2);

endmodule

`default_nettype wire

// ==== source/wallace_mul.sv ====
`timescale 1ns/1ns
`default_nettype none

module wallace_mul import alu_pkg::*; (
  input  wire         clk,
  input  wire         resetn,
  long_op_if.unit     port
);

  logic [MUL_W-1:0] a_ext;
  logic [MUL_W-1:0] b_ext;
  dword_t           pp [MUL_PP_ROWS];
  dword_t           sum;
  dword_t           prod_q;
  logic             done_q;

  // rows left after a number of carry-save layers
  function automatic int rows_after(input int layers);
    int n;
    n = MUL_PP_ROWS;
    for (int k = 0; k < layers; k++) begin
      n = (n / 3) * 2 + n % 3;
    end
    return n;
  endfunction

  assign a_ext = {port.is_signed & port.src1[XLEN-1], port.src1};
  assign b_ext = {port.is_signed & port.src2[XLEN-1], port.src2};

  // Baugh-Wooley rows, sign row and column inverted, product taken mod 2^64
  always_comb begin
    logic pbit;
    for (int i = 0; i < MUL_W; i++) begin
      pp[i] = '0;
      for (int j = 0; j < MUL_W; j++) begin
        pbit = a_ext[j] & b_ext[i];
        if ((i == MUL_W - 1) != (j == MUL_W - 1)) begin
          pbit = ~pbit;
        end
        if (i + j < 2 * XLEN) begin
          pp[i][i+j] = pbit;
        end
      end
    end
    pp[MUL_W] = dword_t'(1) << MUL_W;  // +2^33, the 2^65 term drops out
  end

  // 3:2 compressor layers, leftover rows pass through
  for (genvar l = 0; l <= MUL_CSA_LAYERS; l++) begin : g_layer
    dword_t row [rows_after(l)];
    if (l == 0) begin : g_init
      for (genvar r = 0; r < MUL_PP_ROWS; r++) begin : g_pp
        assign row[r] = pp[r];
      end
    end else begin : g_csa
      for (genvar r = 0; r < rows_after(l - 1) / 3; r++) begin : g_fa
        assign row[2*r]   = g_layer[l-1].row[3*r] ^ g_layer[l-1].row[3*r+1]
                          ^ g_layer[l-1].row[3*r+2];
        assign row[2*r+1] = ((g_layer[l-1].row[3*r]   & g_layer[l-1].row[3*r+1])
                          |  (g_layer[l-1].row[3*r]   & g_layer[l-1].row[3*r+2])
                          |  (g_layer[l-1].row[3*r+1] & g_layer[l-1].row[3*r+2])) << 1;
      end
      for (genvar r = 0; r < rows_after(l - 1) % 3; r++) begin : g_pass
        assign row[2*(rows_after(l-1)/3) + r] = g_layer[l-1].row[3*(rows_after(l-1)/3) + r];
      end
    end
  end

  assign sum = g_layer[MUL_CSA_LAYERS].row[0] + g_layer[MUL_CSA_LAYERS].row[1];

  always_ff @(posedge clk) begin
    if (port.start) begin
      prod_q <= sum;
    end
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      done_q <= 1'b0;
    end else begin
      done_q <= port.start;  // one cycle behind start
    end
  end

  assign port.res_lo = prod_q[XLEN-1:0];
  assign port.res_hi = prod_q[2*XLEN-1:XLEN];
  assign port.done   = done_q;

endmodule

`default_nettype wire

// ==== source/radix2_div.sv ====
`timescale 1ns/1ns
`default_nettype none

module radix2_div import alu_pkg::*; (
  input  wire         clk,
  input  wire         resetn,
  long_op_if.unit     port
);

  logic                 busy_q;
  logic [DIV_CNT_W-1:0] count_q;
  logic                 done_q;
  logic                 last_step;

  word_t         x_mag;
  word_t         y_mag;
  word_t         rem_q;    // partial remainder
  word_t         quo_q;    // dividend shifting out, quotient shifting in
  word_t         dsr_q;    // divisor magnitude
  logic          q_neg_q;
  logic          r_neg_q;
  word_t         quot_q;
  word_t         rmd_q;

  logic [XLEN:0] shifted;
  logic [XLEN:0] diff;
  word_t         rem_next;
  word_t         quo_next;

  // operand magnitudes, 0x80000000 maps to itself as unsigned
  assign x_mag = (port.is_signed & port.src1[XLEN-1]) ? -port.src1 : port.src1;
  assign y_mag = (port.is_signed & port.src2[XLEN-1]) ? -port.src2 : port.src2;

  // one restoring step
  assign shifted  = {rem_q, quo_q[XLEN-1]};
  assign diff     = shifted - {1'b0, dsr_q};
  assign rem_next = diff[XLEN] ? shifted[XLEN-1:0] : diff[XLEN-1:0];  // restore on borrow
  assign quo_next = {quo_q[XLEN-2:0], ~diff[XLEN]};

  assign last_step = busy_q & (count_q == DIV_CNT_W'(DIV_STEPS - 1));

  always_ff @(posedge clk) begin
    if (!resetn) begin
      busy_q  <= 1'b0;
      count_q <= '0;
      done_q  <= 1'b0;
    end else begin
      done_q <= last_step;
      if (port.start) begin
        busy_q  <= 1'b1;
        count_q <= '0;
      end else if (busy_q) begin
        count_q <= count_q + 1'b1;
        if (last_step) begin
          busy_q <= 1'b0;
        end
      end
    end
  end

  // load cycle, then one step per clock
  always_ff @(posedge clk) begin
    if (port.start) begin
      rem_q   <= '0;
      quo_q   <= x_mag;
      dsr_q   <= y_mag;
      q_neg_q <= port.is_signed & (port.src1[XLEN-1] ^ port.src2[XLEN-1]);
      r_neg_q <= port.is_signed & port.src1[XLEN-1];  // remainder follows dividend
    end else if (busy_q) begin
      rem_q <= rem_next;
      quo_q <= quo_next;
    end
  end

  // sign fix-up in the same cycle as the final step
  always_ff @(posedge clk) begin
    if (last_step) begin
      quot_q <= q_neg_q ? -quo_next : quo_next;
      rmd_q  <= r_neg_q ? -rem_next : rem_next;
    end
  end

  assign port.res_lo = quot_q;
  assign port.res_hi = rmd_q;
  assign port.done   = done_q;

endmodule

`default_nettype wire

// ==== source/alu_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

module alu_ctrl import alu_pkg::*; (
  input  wire         clk,
  input  wire         resetn,
  input  alu_op_t     alu_op,
  input  word_t       src1,
  input  word_t       src2,
  input  word_t       simple_result,
  long_op_if.ctrl     mul,
  long_op_if.ctrl     div,
  output word_t       alu_result,
  output logic        complete
);

  ctrl_state_t state_q;
  ctrl_state_t state_d;
  logic        mul_class;
  logic        div_class;
  dword_t      product;

  assign mul_class = alu_op[OP_MUL] | alu_op[OP_MULH] | alu_op[OP_MULHU];
  assign div_class = alu_op[OP_DIV] | alu_op[OP_DIVU] | alu_op[OP_MOD] | alu_op[OP_MODU];

  // start only from IDLE, mul wins on a malformed op
  assign mul.start     = (state_q == IDLE) & mul_class;
  assign mul.is_signed = alu_op[OP_MUL] | alu_op[OP_MULH];
  assign mul.src1      = src1;
  assign mul.src2      = src2;

  assign div.start     = (state_q == IDLE) & div_class & ~mul_class;
  assign div.is_signed = alu_op[OP_DIV] | alu_op[OP_MOD];
  assign div.src1      = src1;
  assign div.src2      = src2;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      IDLE: begin
        if (mul_class) begin
          state_d = MUL_WAIT;
        end else if (div_class) begin
          state_d = DIV_WAIT;
        end
      end
      MUL_WAIT: if (mul.done) state_d = IDLE;
      DIV_WAIT: if (div.done) state_d = IDLE;
      default:  state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  assign complete = ((state_q == IDLE) & ~mul_class & ~div_class)
                  | ((state_q == MUL_WAIT) & mul.done)
                  | ((state_q == DIV_WAIT) & div.done);

  assign product = {mul.res_hi, mul.res_lo};

  assign alu_result = simple_result  // zero for long ops
                    | ({XLEN{alu_op[OP_MUL]}}                    & product[XLEN-1:0])
                    | ({XLEN{alu_op[OP_MULH] | alu_op[OP_MULHU]}} & product[2*XLEN-1:XLEN])
                    | ({XLEN{alu_op[OP_DIV] | alu_op[OP_DIVU]}}   & div.res_lo)
                    | ({XLEN{alu_op[OP_MOD] | alu_op[OP_MODU]}}   & div.res_hi);

endmodule

`default_nettype wire

// ==== source/alu.sv ====
`timescale 1ns/1ns
`default_nettype none

module alu import alu_pkg::*; (
  input  wire     clk,
  input  wire     resetn,
  input  alu_op_t alu_op,
  input  word_t   alu_src1,
  input  word_t   alu_src2,
  output word_t   alu_result,
  output logic    complete
);

  word_t simple_result;

  long_op_if mul_bus ();
  long_op_if div_bus ();

  alu_simple u_simple (
    .alu_op (alu_op),
    .src1   (alu_src1),
    .src2   (alu_src2),
    .result (simple_result)
  );

  alu_ctrl u_ctrl (
    .clk           (clk),
    .resetn        (resetn),
    .alu_op        (alu_op),
    .src1          (alu_src1),
    .src2          (alu_src2),
    .simple_result (simple_result),
    .mul           (mul_bus.ctrl),
    .div           (div_bus.ctrl),
    .alu_result    (alu_result),
    .complete      (complete)
  );

  wallace_mul u_mul (
    .clk    (clk),
    .resetn (resetn),
    .port   (mul_bus.unit)
  );

  radix2_div u_div (
    .clk    (clk),
    .resetn (resetn),
    .port   (div_bus.unit)
  );

endmodule

`default_nettype wire

// ==== verif/alu_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module alu_tb import alu_pkg::*; ();

  localparam int CLK_PERIOD = 100;
  localparam int SETTLE     = 10;  // sample point after the falling edge
  localparam int NUM_RAND   = 40;
  localparam int MAX_WAIT   = 40;  // cycles allowed per table entry

  logic    clk;
  logic    resetn;
  alu_op_t alu_op;
  word_t   alu_src1;
  word_t   alu_src2;
  word_t   alu_result;
  logic    complete;

  int      tbl_op [$];
  word_t   tbl_a [$];
  word_t   tbl_b [$];
  logic    table_ready;
  int      seed;

  alu UUT (
    .clk        (clk),
    .resetn     (resetn),
    .alu_op     (alu_op),
    .alu_src1   (alu_src1),
    .alu_src2   (alu_src2),
    .alu_result (alu_result),
    .complete   (complete)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("CHECKS FAILED");
    $fatal(1, "run stopped at the first failure");
  endtask

  task automatic check_word(input string name, input word_t got, input word_t expected);
    if (got !== expected) begin
      report_failure($sformatf("error at time %0t: %s got 0x%08h expected 0x%08h",
                               $time, name, got, expected));
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic expected);
    if (got !== expected) begin
      report_failure($sformatf("error at time %0t: %s got %b expected %b",
                               $time, name, got, expected));
    end
  endtask

  task automatic check_latency(input string name, input int got, input int expected);
    if (got != expected) begin
      report_failure($sformatf("error at time %0t: %s got %0d expected %0d cycles",
                               $time, name, got, expected));
    end
  endtask

  task automatic add_entry(input int op, input word_t a, input word_t b);
    tbl_op.push_back(op);
    tbl_a.push_back(a);
    tbl_b.push_back(b);
  endtask

  // reference model on 64-bit copies of the operands
  function automatic word_t ref_result(input int op, input word_t a, input word_t b);
    longint          sa;
    longint          sb;
    longint unsigned ua;
    longint unsigned ub;
    longint          res;
    sa = longint'($signed(a));
    sb = longint'($signed(b));
    ua = a;
    ub = b;
    case (op)
      OP_ADD:   res = ua + ub;
      OP_SUB:   res = ua - ub;
      OP_SLT:   res = (sa < sb) ? 1 : 0;
      OP_SLTU:  res = (ua < ub) ? 1 : 0;
      OP_AND:   res = ua & ub;
      OP_NOR:   res = ~(ua | ub);
      OP_OR:    res = ua | ub;
      OP_XOR:   res = ua ^ ub;
      OP_SLL:   res = ua << b[4:0];
      OP_SRL:   res = ua >> b[4:0];
      OP_SRA:   res = sa >>> b[4:0];
      OP_LUI:   res = ub;
      OP_MUL:   res = sa * sb;
      OP_MULH:  res = (sa * sb) >>> 32;
      OP_MULHU: res = (ua * ub) >> 32;
      OP_DIV:   res = sa / sb;  // truncates toward zero
      OP_DIVU:  res = ua / ub;
      OP_MOD:   res = sa % sb;  // sign of the dividend
      OP_MODU:  res = ua % ub;
      default:  res = 0;
    endcase
    return res[31:0];
  endfunction

  function automatic int expected_latency(input int op);
    if (op >= OP_MUL && op <= OP_MULHU) begin
      return 1;
    end else if (op >= OP_DIV) begin
      return DIV_STEPS + 1;
    end
    return 0;
  endfunction

  initial begin
    int    op;
    int    lat;
    word_t b;
    string tag;

    resetn      = 1'b0;
    alu_op      = '0;
    alu_src1    = 32'h89abcdef;  // nonzero operands while idle
    alu_src2    = 32'h76543210;
    table_ready = 1'b0;
    seed        = 36;

    // corner values
    add_entry(OP_ADD,   32'hffffffff, 32'h00000001);
    add_entry(OP_ADD,   32'h7fffffff, 32'h00000001);
    add_entry(OP_SUB,   32'h00000000, 32'h00000001);
    add_entry(OP_SLT,   32'hffffffff, 32'h00000001);
    add_entry(OP_SLT,   32'h80000000, 32'h7fffffff);
    add_entry(OP_SLT,   32'h00000001, 32'hffffffff);
    add_entry(OP_SLTU,  32'hffffffff, 32'h00000001);
    add_entry(OP_SLTU,  32'h00000001, 32'hffffffff);
    add_entry(OP_AND,   32'hf0f0f0f0, 32'hffff0000);
    add_entry(OP_NOR,   32'h00000000, 32'h00000000);
    add_entry(OP_OR,    32'h12345678, 32'h87654321);
    add_entry(OP_XOR,   32'hffffffff, 32'ha5a5a5a5);
    add_entry(OP_SLL,   32'h00000001, 32'h0000001f);
    add_entry(OP_SLL,   32'hffffffff, 32'h00000000);
    add_entry(OP_SRL,   32'h80000000, 32'h0000001f);
    add_entry(OP_SRA,   32'h80000000, 32'h0000001f);
    add_entry(OP_SRA,   32'h80000000, 32'h00000000);
    add_entry(OP_LUI,   32'h00000000, 32'h12345000);
    add_entry(OP_MUL,   32'hffffffff, 32'hffffffff);
    add_entry(OP_MUL,   32'h80000000, 32'h80000000);
    add_entry(OP_MULH,  32'h80000000, 32'h7fffffff);
    add_entry(OP_MULH,  32'hffffffff, 32'h00000001);
    add_entry(OP_MULHU, 32'hffffffff, 32'hffffffff);
    add_entry(OP_DIV,   32'h00000007, 32'hfffffffe);
    add_entry(OP_DIV,   32'h80000000, 32'hffffffff);
    add_entry(OP_DIVU,  32'hffffffff, 32'h00000002);
    add_entry(OP_MOD,   32'hfffffff9, 32'h00000002);
    add_entry(OP_MODU,  32'hffffffff, 32'h00000010);

    for (int i = 0; i < NUM_RAND; i++) begin
      op = $unsigned($random(seed)) % OP_W;
      b  = $random(seed);
      if (op >= OP_DIV && b == '0) begin
        b = 32'h1;  // no divide by zero
      end
      add_entry(op, $random(seed), b);
    end
    table_ready = 1'b1;

    repeat (10) @(negedge clk);
    resetn = 1'b1;
    @(negedge clk);
    #SETTLE;
    check_flag("complete after reset", complete, 1'b1);
    check_word("alu_result after reset", alu_result, '0);

    for (int i = 0; i < tbl_op.size(); i++) begin
      @(negedge clk);
      alu_op   = alu_op_t'(1) << tbl_op[i];
      alu_src1 = tbl_a[i];
      alu_src2 = tbl_b[i];
      tag = $sformatf("op %0d src1 0x%08h src2 0x%08h", tbl_op[i], tbl_a[i], tbl_b[i]);
      #SETTLE;
      lat = 0;
      while (!complete) begin  // counts falling edges until complete
        @(negedge clk);
        #SETTLE;
        lat++;
        if (lat > MAX_WAIT) begin
          report_failure({"complete stayed low too long for ", tag});
        end
      end
      check_latency({"latency of ", tag}, lat, expected_latency(tbl_op[i]));
      check_word({"alu_result for ", tag}, alu_result, ref_result(tbl_op[i], tbl_a[i], tbl_b[i]));
      @(negedge clk);
      alu_op = '0;
      #SETTLE;
      check_flag("complete with no op", complete, 1'b1);
      check_word("alu_result with no op", alu_result, '0);
    end

    @(negedge clk);
    $display("ALL CHECKS PASSED");
    $finish;
  end

  // watchdog sized from the table
  initial begin
    wait (table_ready);
    #(tbl_op.size() * MAX_WAIT * CLK_PERIOD);
    report_failure("timeout: complete never came within the time allowed for the table");
  end

endmodule

`default_nettype wire

// ==== all.f ====
source/alu_pkg.sv
source/long_op_if.sv
source/alu_simple.sv
source/wallace_mul.sv
source/radix2_div.sv
source/alu_ctrl.sv
source/alu.sv
verif/alu_tb.sv

// ==== Bender.yml ====
package:
  name: alu

sources:
  - source/alu_pkg.sv
  - source/long_op_if.sv
  - source/alu_simple.sv
  - source/wallace_mul.sv
  - source/radix2_div.sv
  - source/alu_ctrl.sv
  - source/alu.sv
  - target: test
    files:
      - verif/alu_tb.sv
